// ==== decode_stage_top.f ====
logic/rv_decode_pkg.sv
logic/fetch_bus_if.sv
logic/fetch_skid_buffer.sv
logic/reg_file.sv
logic/instr_decoder.sv
logic/decode_stage_top.sv
dv/decode_checker.sv
dv/decode_tb.sv

// ==== dv/decode_checker.sv ====
`timescale 1ns/1ps

module decode_checker import rv_decode_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        flush,
    input  logic        prev_stalled,
    input  logic        stall_prev,
    input  logic        fetch_exception,
    input  trap_cause_t fetch_trap_cause,
    input  inst_t       fetch_instruction,
    input  inst_t       fetch_original_instruction,
    input  addr_t       fetch_addr,
    input  addr_t       fetch_next_addr,
    input  logic        exec_valid,
    input  reg_idx_t    exec_reg,
    input  xlen_t       exec_data,
    input  logic        wb_valid,
    input  reg_idx_t    wb_reg,
    input  xlen_t       wb_data,
    input  logic        next_stalled,
    input  logic        stall_next,
    input  logic        dec_exception,
    input  trap_cause_t dec_trap_cause,
    input  logic        dec_is_jump,
    input  logic        dec_is_reg_write,
    input  opcode_t     dec_opcode,
    input  reg_idx_t    dec_rd,
    input  reg_idx_t    dec_rs1,
    input  reg_idx_t    dec_rs2,
    input  logic [2:0]  dec_funct3,
    input  logic [6:0]  dec_funct7,
    input  logic [11:0] dec_i_imm,
    input  logic [11:0] dec_s_imm,
    input  logic [11:0] dec_b_imm,
    input  logic [19:0] dec_u_imm,
    input  logic [19:0] dec_j_imm,
    input  xlen_t       dec_rs1_data,
    input  xlen_t       dec_rs2_data,
    input  inst_t       dec_original_instruction,
    input  addr_t       dec_addr,
    input  addr_t       dec_next_addr,
    output int          error_count,
    output int          pending
);

    typedef struct packed {
        logic        exception;
        trap_cause_t trap_cause;
        logic        is_jump;
        logic        is_reg_write;
        logic [4:0]  opcode;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        logic [2:0]  funct3;
        logic [6:0]  funct7;
        logic [11:0] i_imm;
        logic [11:0] s_imm;
        logic [11:0] b_imm;
        logic [19:0] u_imm;
        logic [19:0] j_imm;
        xlen_t       rs1_data;
        xlen_t       rs2_data;
        inst_t       original_instruction;
        addr_t       addr;
        addr_t       next_addr;
    } item_t;

    item_t exp_q[$];
    item_t hold_item;
    item_t got;
    item_t exp;
    logic  hold_valid;
    logic  flush_seen;
    xlen_t model [NUM_REGS];

    // Operand as the ISA pipeline expects it, x0 first then youngest producer
    function automatic xlen_t ref_operand(input reg_idx_t idx);
        if (idx == 5'd0) begin
            return '0;
        end
        if (exec_valid && exec_reg == idx) begin
            return exec_data;
        end
        if (wb_valid && wb_reg == idx) begin
            return wb_data;
        end
        return model[idx];
    endfunction

    function automatic item_t ref_decode(input inst_t w);
        item_t e;
        e.opcode               = w[6:2];
        e.rd                   = w[11:7];
        e.rs1                  = w[19:15];
        e.rs2                  = w[24:20];
        e.funct3               = w[14:12];
        e.funct7               = w[31:25];
        e.i_imm                = w[31:20];
        e.s_imm                = {w[31:25], w[11:7]};
        e.b_imm                = {w[31], w[7], w[30:25], w[11:8]};
        e.u_imm                = w[31:12];
        e.j_imm                = {w[31], w[19:12], w[20], w[30:21]};
        e.is_jump              = (w[6:4] == 3'b110);
        e.is_reg_write         = !(w[6:2] == OP_STORE || w[6:2] == OP_BRANCH);
        e.rs1_data             = ref_operand(w[19:15]);
        e.rs2_data             = ref_operand(w[24:20]);
        e.original_instruction = fetch_original_instruction;
        e.addr                 = fetch_addr;
        e.next_addr            = fetch_next_addr;
        if (fetch_exception) begin
            e.exception  = 1'b1;
            e.trap_cause = fetch_trap_cause;
        end else if (w[1:0] != 2'b11) begin
            e.exception  = 1'b1;
            e.trap_cause = CAUSE_ILLEGAL_INSTR;
        end else begin
            e.exception  = 1'b0;
            e.trap_cause = '0;
        end
        return e;
    endfunction

    function automatic item_t observed_item();
        return {dec_exception, dec_trap_cause, dec_is_jump, dec_is_reg_write,
                dec_opcode, dec_rd, dec_rs1, dec_rs2, dec_funct3, dec_funct7,
                dec_i_imm, dec_s_imm, dec_b_imm, dec_u_imm, dec_j_imm,
                dec_rs1_data, dec_rs2_data, dec_original_instruction,
                dec_addr, dec_next_addr};
    endfunction

    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            exp_q.delete();
            hold_valid = 1'b0;
            flush_seen = 1'b0;
            pending    = 0;
            for (int i = 0; i < NUM_REGS; i++) begin
                model[i] = '0;
            end
        end else begin
            if (flush_seen && !stall_next) begin
                $display("stall_next was low in the cycle right after a flush");
                error_count++;
            end
            if (flush) begin
                // Everything in flight is dropped, including a same-edge accept
                exp_q.delete();
                hold_valid = 1'b0;
                flush_seen = 1'b1;
            end else begin
                flush_seen = 1'b0;
                got = observed_item();
                if (hold_valid && got != hold_item) begin
                    $display("ERR %0t: output changed while stalled, was %h now %h",
                             $time, hold_item, got);
                    error_count++;
                end
                if (!stall_next && !next_stalled) begin
                    hold_valid = 1'b0;
                    if (exp_q.size() == 0) begin
                        $display("an item left the output with no expected item queued");
                        error_count++;
                    end else begin
                        exp = exp_q.pop_front();
                        if (got != exp) begin
                            $display("ERR %0t: decoded item mismatch at addr %h, exp %h got %h",
                                     $time, exp.addr, exp, got);
                            error_count++;
                        end
                    end
                end else if (!stall_next) begin
                    hold_item  = got;
                    hold_valid = 1'b1;
                end else begin
                    hold_valid = 1'b0;
                end
                if (!prev_stalled && !stall_prev) begin
                    exp_q.push_back(ref_decode(fetch_instruction));
                end
            end
            if (wb_valid && wb_reg != 5'd0) begin
                model[wb_reg] = wb_data;
            end
            pending = exp_q.size();
        end
    end

endmodule

// ==== dv/decode_tb.sv ====
`timescale 1ns/1ps

module decode_tb import rv_decode_pkg::*; ();

    localparam int N_BYPASS  = 200;
    localparam int N_EXCEPT  = 60;
    localparam int N_STALL   = 150;
    localparam int N_FLUSH   = 6;
    localparam int N_TOTAL   = N_BYPASS + N_EXCEPT + N_STALL + N_FLUSH;
    localparam int CYCLE_LIMIT = 4 * N_TOTAL + 200;

    logic clk, arst_n, flush, prev_stalled, stall_prev;
    logic fetch_exception;
    trap_cause_t fetch_trap_cause;
    inst_t fetch_instruction, fetch_original_instruction;
    addr_t fetch_addr, fetch_next_addr;
    logic exec_valid, wb_valid, next_stalled, stall_next;
    reg_idx_t exec_reg, wb_reg;
    xlen_t exec_data, wb_data;
    logic dec_exception, dec_is_jump, dec_is_reg_write;
    trap_cause_t dec_trap_cause;
    opcode_t dec_opcode;
    reg_idx_t dec_rd, dec_rs1, dec_rs2;
    logic [2:0] dec_funct3;
    logic [6:0] dec_funct7;
    logic [11:0] dec_i_imm, dec_s_imm, dec_b_imm;
    logic [19:0] dec_u_imm, dec_j_imm;
    xlen_t dec_rs1_data, dec_rs2_data;
    inst_t dec_original_instruction;
    addr_t dec_addr, dec_next_addr;
    int error_count, pending;

    int          tb_errors;
    int          cycles;
    logic [31:0] rng_state;
    addr_t       pc;
    opcode_t     opcodes [10] = '{OP_LOAD, OP_STORE, OP_BRANCH, OP_JALR, OP_JAL,
                                  OP_OP_IMM, OP_OP, OP_LUI, OP_AUIPC, OP_SYSTEM};

    decode_stage_top dut_i (.*);
    decode_checker   checker_i (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAILED");
            $finish;
        end
    end

    function logic [31:0] xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Pick a bypass register that often hits one of the sources
    function reg_idx_t pick_reg(input inst_t w);
        logic [31:0] r;
        r = xorshift32();
        case (r[1:0])
            2'd0:    return w[19:15];
            2'd1:    return w[24:20];
            default: return r[8:4];
        endcase
    endfunction

    // kind 0 legal with bypass traffic, 1 exception mix, 2 legal and quiet buses
    task new_packet(input int kind);
        inst_t       w;
        logic [31:0] r;
        w = xorshift32();
        r = xorshift32();
        w[6:2] = opcodes[r % 10];
        if (kind != 1 || r[4]) begin
            w[1:0] = 2'b11;
        end
        fetch_instruction          = w;
        fetch_original_instruction = xorshift32();
        fetch_exception            = (kind == 1) && (r[9:8] == 2'b00);
        fetch_trap_cause           = r[15:12];
        fetch_addr                 = pc;
        fetch_next_addr            = pc + 32'd4;
        pc                         = pc + 32'd4;
        exec_valid                 = (kind == 0) && r[20];
        exec_reg                   = pick_reg(w);
        exec_data                  = xorshift32();
        wb_valid                   = (kind == 0) && r[21];
        wb_reg                     = pick_reg(w);
        wb_data                    = xorshift32();
    endtask

    // Called 1 ns after a rising edge, returns at the same point
    task stream_items(input int n, input int kind, input bit rand_stall, input bit hold_next);
        int   accepted;
        logic acc;
        accepted = 0;
        new_packet(kind);
        prev_stalled = 1'b0;
        next_stalled = hold_next;
        while (accepted < n) begin
            @(negedge clk);
            acc = !prev_stalled && !stall_prev;
            @(posedge clk);
            #1;
            if (acc) begin
                accepted++;
                if (accepted < n) begin
                    new_packet(kind);
                end
            end
            prev_stalled = (accepted >= n) || (rand_stall && xorshift32() % 4 == 0);
            next_stalled = hold_next || (rand_stall && xorshift32() % 4 == 0);
        end
        exec_valid = 1'b0;
        wb_valid   = 1'b0;
    endtask

    // Let downstream take everything still queued, up to a cycle limit
    task drain_items(input int max_cycles);
        int waited;
        waited = 0;
        next_stalled = 1'b0;
        while (pending != 0 && waited < max_cycles) begin
            @(posedge clk);
            #1;
            waited++;
        end
    endtask

    initial begin
        rng_state = 32'h77c1;
        pc = 32'h0000_1000;
        tb_errors = 0;
        cycles = 0;
        arst_n = 1'b0;
        flush = 1'b0;
        prev_stalled = 1'b1;
        next_stalled = 1'b0;
        fetch_exception = 1'b0;
        fetch_trap_cause = '0;
        fetch_instruction = '0;
        fetch_original_instruction = '0;
        fetch_addr = '0;
        fetch_next_addr = '0;
        exec_valid = 1'b0;
        exec_reg = '0;
        exec_data = '0;
        wb_valid = 1'b0;
        wb_reg = '0;
        wb_data = '0;

        repeat (8) @(posedge clk);
        #1;
        arst_n = 1'b1;
        if (stall_next !== 1'b1 || stall_prev !== 1'b0) begin
            $display("handshake outputs wrong after reset");
            tb_errors++;
        end

        stream_items(N_BYPASS, 0, 1'b0, 1'b0);
        stream_items(N_EXCEPT, 1, 1'b0, 1'b0);
        stream_items(N_STALL, 2, 1'b1, 1'b0);
        drain_items(16);

        // Fill slot and skid buffer, then flush both
        stream_items(2, 2, 1'b0, 1'b1);
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        next_stalled = 1'b0;
        if (stall_next !== 1'b1) begin
            $display("stall_next not high right after flush");
            tb_errors++;
        end
        stream_items(N_FLUSH - 2, 2, 1'b0, 1'b0);

        drain_items(16);
        if (pending != 0) begin
            $display("items were left unchecked at the end of the run");
            tb_errors++;
        end

        $display("errors: checker %0d, testbench %0d", error_count, tb_errors);
        if (error_count + tb_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== logic/decode_stage_top.sv ====
`timescale 1ns/1ps

module decode_stage_top import rv_decode_pkg::*; #(
    parameter int NUM_REGS = rv_decode_pkg::NUM_REGS
) (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        flush,

    input  logic        prev_stalled,
    output logic        stall_prev,
    input  logic        fetch_exception,
    input  trap_cause_t fetch_trap_cause,
    input  inst_t       fetch_instruction,
    input  inst_t       fetch_original_instruction,
    input  addr_t       fetch_addr,
    input  addr_t       fetch_next_addr,

    input  logic        exec_valid,
    input  reg_idx_t    exec_reg,
    input  xlen_t       exec_data,
    input  logic        wb_valid,
    input  reg_idx_t    wb_reg,
    input  xlen_t       wb_data,

    input  logic        next_stalled,
    output logic        stall_next,
    output logic        dec_exception,
    output trap_cause_t dec_trap_cause,
    output logic        dec_is_jump,
    output logic        dec_is_reg_write,
    output opcode_t     dec_opcode,
    output reg_idx_t    dec_rd,
    output reg_idx_t    dec_rs1,
    output reg_idx_t    dec_rs2,
    output logic [2:0]  dec_funct3,
    output logic [6:0]  dec_funct7,
    output logic [11:0] dec_i_imm,
    output logic [11:0] dec_s_imm,
    output logic [11:0] dec_b_imm,
    output logic [19:0] dec_u_imm,
    output logic [19:0] dec_j_imm,
    output xlen_t       dec_rs1_data,
    output xlen_t       dec_rs2_data,
    output inst_t       dec_original_instruction,
    output addr_t       dec_addr,
    output addr_t       dec_next_addr
);

    reg_idx_t rs_idx1;
    reg_idx_t rs_idx2;
    xlen_t    rs_val1;
    xlen_t    rs_val2;

    fetch_bus_if fetch_bus ();

    fetch_skid_buffer skid_i (
        .clk                  (clk),
        .arst_n               (arst_n),
        .flush                (flush),
        .prev_stalled         (prev_stalled),
        .stall_prev           (stall_prev),
        .exception            (fetch_exception),
        .trap_cause           (fetch_trap_cause),
        .instruction          (fetch_instruction),
        .original_instruction (fetch_original_instruction),
        .addr                 (fetch_addr),
        .next_addr            (fetch_next_addr),
        .bus                  (fetch_bus.src)
    );

    instr_decoder decoder_i (
        .clk                  (clk),
        .arst_n               (arst_n),
        .flush                (flush),
        .bus                  (fetch_bus.dst),
        .rs_idx1              (rs_idx1),
        .rs_idx2              (rs_idx2),
        .rs_val1              (rs_val1),
        .rs_val2              (rs_val2),
        .exec_valid           (exec_valid),
        .exec_reg             (exec_reg),
        .exec_data            (exec_data),
        .wb_valid             (wb_valid),
        .wb_reg               (wb_reg),
        .wb_data              (wb_data),
        .next_stalled         (next_stalled),
        .stall_next           (stall_next),
        .exception            (dec_exception),
        .trap_cause           (dec_trap_cause),
        .is_jump              (dec_is_jump),
        .is_reg_write         (dec_is_reg_write),
        .opcode               (dec_opcode),
        .rd                   (dec_rd),
        .rs1                  (dec_rs1),
        .rs2                  (dec_rs2),
        .funct3               (dec_funct3),
        .funct7               (dec_funct7),
        .i_imm                (dec_i_imm),
        .s_imm                (dec_s_imm),
        .b_imm                (dec_b_imm),
        .u_imm                (dec_u_imm),
        .j_imm                (dec_j_imm),
        .rs1_data             (dec_rs1_data),
        .rs2_data             (dec_rs2_data),
        .original_instruction (dec_original_instruction),
        .addr                 (dec_addr),
        .next_addr            (dec_next_addr)
    );

    // Writeback bus doubles as the register file write port
    reg_file #(
        .NUM_ENTRIES (NUM_REGS)
    ) regs_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .rd_idx1  (rs_idx1),
        .rd_idx2  (rs_idx2),
        .rd_data1 (rs_val1),
        .rd_data2 (rs_val2),
        .wr_en    (wb_valid),
        .wr_idx   (wb_reg),
        .wr_data  (wb_data)
    );

endmodule

// ==== logic/fetch_bus_if.sv ====
`timescale 1ns/1ps

interface fetch_bus_if import rv_decode_pkg::*; ();

    logic        valid;
    logic        take;
    logic        exception;
    trap_cause_t trap_cause;
    inst_t       instruction;
    inst_t       original_instruction;
    addr_t       addr;
    addr_t       next_addr;

    modport src (
        output valid,
        output exception,
        output trap_cause,
        output instruction,
        output original_instruction,
        output addr,
        output next_addr,
        input  take
    );

    modport dst (
        input  valid,
        input  exception,
        input  trap_cause,
        input  instruction,
        input  original_instruction,
        input  addr,
        input  next_addr,
        output take
    );

endinterface

// ==== logic/fetch_skid_buffer.sv ====
`timescale 1ns/1ps

module fetch_skid_buffer import rv_decode_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        flush,
    input  logic        prev_stalled,
    output logic        stall_prev,
    input  logic        exception,
    input  trap_cause_t trap_cause,
    input  inst_t       instruction,
    input  inst_t       original_instruction,
    input  addr_t       addr,
    input  addr_t       next_addr,
    fetch_bus_if.src    bus
);

    logic        buf_full;
    logic        skid_exception;
    trap_cause_t skid_trap_cause;
    inst_t       skid_instruction;
    inst_t       skid_original_instruction;
    addr_t       skid_addr;
    addr_t       skid_next_addr;

    // Upstream is held off only while an item sits in the skid register
    assign stall_prev = buf_full;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            buf_full <= 1'b0;
        end else if (flush) begin
            buf_full <= 1'b0;
        end else if (buf_full) begin
            if (bus.take) begin
                buf_full <= 1'b0;
            end
        end else if (!prev_stalled && !bus.take) begin
            buf_full <= 1'b1;
        end
    end

    // Skid register follows the input until it is parked
    always_ff @(posedge clk) begin
        if (!buf_full) begin
            skid_exception            <= exception;
            skid_trap_cause           <= trap_cause;
            skid_instruction          <= instruction;
            skid_original_instruction <= original_instruction;
            skid_addr                 <= addr;
            skid_next_addr            <= next_addr;
        end
    end

    always_comb begin
        if (buf_full) begin
            bus.valid                = 1'b1;
            bus.exception            = skid_exception;
            bus.trap_cause           = skid_trap_cause;
            bus.instruction          = skid_instruction;
            bus.original_instruction = skid_original_instruction;
            bus.addr                 = skid_addr;
            bus.next_addr            = skid_next_addr;
        end else begin
            bus.valid                = !prev_stalled;
            bus.exception            = exception;
            bus.trap_cause           = trap_cause;
            bus.instruction          = instruction;
            bus.original_instruction = original_instruction;
            bus.addr                 = addr;
            bus.next_addr            = next_addr;
        end
    end

    // An item accepted but not taken is parked and blocks further acceptance
    property park_blocks_upstream;
        @(posedge clk) disable iff (!arst_n)
        (!prev_stalled && !stall_prev && !bus.take && !flush)
            |=> (stall_prev && bus.valid &&
                 {bus.exception, bus.trap_cause, bus.instruction,
                  bus.original_instruction, bus.addr, bus.next_addr} ==
                 $past({exception, trap_cause, instruction,
                        original_instruction, addr, next_addr}));
    endproperty

    park_blocks_upstream_a: assert property (park_blocks_upstream)
        else $error("skid buffer lost the item it parked");

endmodule

// ==== logic/instr_decoder.sv ====
`timescale 1ns/1ps

module instr_decoder import rv_decode_pkg::*; (
    input  logic        clk,
    input  logic        arst_n,
    input  logic        flush,
    fetch_bus_if.dst    bus,
    output reg_idx_t    rs_idx1,
    output reg_idx_t    rs_idx2,
    input  xlen_t       rs_val1,
    input  xlen_t       rs_val2,
    input  logic        exec_valid,
    input  reg_idx_t    exec_reg,
    input  xlen_t       exec_data,
    input  logic        wb_valid,
    input  reg_idx_t    wb_reg,
    input  xlen_t       wb_data,
    input  logic        next_stalled,
    output logic        stall_next,
    output logic        exception,
    output trap_cause_t trap_cause,
    output logic        is_jump,
    output logic        is_reg_write,
    output opcode_t     opcode,
    output reg_idx_t    rd,
    output reg_idx_t    rs1,
    output reg_idx_t    rs2,
    output logic [2:0]  funct3,
    output logic [6:0]  funct7,
    output logic [11:0] i_imm,
    output logic [11:0] s_imm,
    output logic [11:0] b_imm,
    output logic [19:0] u_imm,
    output logic [19:0] j_imm,
    output xlen_t       rs1_data,
    output xlen_t       rs2_data,
    output inst_t       original_instruction,
    output addr_t       addr,
    output addr_t       next_addr
);

    logic    slot_valid;
    logic    load;
    inst_t   instr;
    opcode_t opcode_in;
    xlen_t   op1_sel;
    xlen_t   op2_sel;

    // Newest producer wins
    function automatic xlen_t select_operand(
        input reg_idx_t idx,
        input xlen_t    rf_val,
        input logic     ex_v,
        input reg_idx_t ex_r,
        input xlen_t    ex_d,
        input logic     wb_v,
        input reg_idx_t wb_r,
        input xlen_t    wb_d
    );
        if (idx == '0) begin
            return '0;
        end else if (ex_v && ex_r == idx) begin
            return ex_d;
        end else if (wb_v && wb_r == idx) begin
            return wb_d;
        end
        return rf_val;
    endfunction

    assign instr     = bus.instruction;
    assign opcode_in = opcode_t'(instr[6:2]);
    assign rs_idx1   = instr[19:15];
    assign rs_idx2   = instr[24:20];

    // Slot accepts when empty or when its item leaves at this edge
    assign bus.take   = !slot_valid || !next_stalled;
    assign load       = bus.valid && bus.take;
    assign stall_next = !slot_valid;

    always_comb begin
        op1_sel = select_operand(rs_idx1, rs_val1, exec_valid, exec_reg, exec_data,
                                 wb_valid, wb_reg, wb_data);
        op2_sel = select_operand(rs_idx2, rs_val2, exec_valid, exec_reg, exec_data,
                                 wb_valid, wb_reg, wb_data);
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            slot_valid <= 1'b0;
        end else if (flush) begin
            slot_valid <= 1'b0;
        end else if (load) begin
            slot_valid <= 1'b1;
        end else if (!next_stalled) begin
            slot_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            opcode       <= opcode_in;
            rd           <= instr[11:7];
            rs1          <= rs_idx1;
            rs2          <= rs_idx2;
            funct3       <= instr[14:12];
            funct7       <= instr[31:25];
            i_imm        <= instr[31:20];
            s_imm        <= {instr[31:25], instr[11:7]};
            b_imm        <= {instr[31], instr[7], instr[30:25], instr[11:8]};
            u_imm        <= instr[31:12];
            j_imm        <= {instr[31], instr[19:12], instr[20], instr[30:21]};
            is_jump      <= instr[6:4] == 3'b110;
            is_reg_write <= opcode_in != OP_STORE && opcode_in != OP_BRANCH;
            rs1_data     <= op1_sel;
            rs2_data     <= op2_sel;

            original_instruction <= bus.original_instruction;
            addr                 <= bus.addr;
            next_addr            <= bus.next_addr;

            // Fetch faults take precedence over a bad encoding
            if (bus.exception) begin
                exception  <= 1'b1;
                trap_cause <= bus.trap_cause;
            end else if (instr[1:0] != 2'b11) begin
                exception  <= 1'b1;
                trap_cause <= CAUSE_ILLEGAL_INSTR;
            end else begin
                exception  <= 1'b0;
                trap_cause <= '0;
            end
        end
    end

    // A refused item stays put, payload and operands alike
    property slot_holds_under_stall;
        @(posedge clk) disable iff (!arst_n)
        (slot_valid && next_stalled && !flush)
            |=> (slot_valid && $stable({exception, trap_cause, is_jump, is_reg_write,
                                        opcode, rd, rs1, rs2, funct3, funct7,
                                        i_imm, s_imm, b_imm, u_imm, j_imm,
                                        rs1_data, rs2_data, original_instruction,
                                        addr, next_addr}));
    endproperty

    slot_holds_under_stall_a: assert property (slot_holds_under_stall)
        else $error("decoded item changed while downstream stalled");

endmodule

// ==== logic/reg_file.sv ====
`timescale 1ns/1ps

module reg_file import rv_decode_pkg::*; #(
    parameter int NUM_ENTRIES = NUM_REGS
) (
    input  logic     clk,
    input  logic     arst_n,
    input  reg_idx_t rd_idx1,
    input  reg_idx_t rd_idx2,
    output xlen_t    rd_data1,
    output xlen_t    rd_data2,
    input  logic     wr_en,
    input  reg_idx_t wr_idx,
    input  xlen_t    wr_data
);

    xlen_t regs [NUM_ENTRIES];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_ENTRIES; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_idx != '0) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // x0 is hardwired, the write above never touches entry 0
    assign rd_data1 = (rd_idx1 == '0) ? '0 : regs[rd_idx1];
    assign rd_data2 = (rd_idx2 == '0) ? '0 : regs[rd_idx2];

endmodule

// ==== logic/rv_decode_pkg.sv ====
package rv_decode_pkg;

    localparam int XLEN = 32;
    localparam int ILEN = 32;
    localparam int ALEN = 32;

    // Architectural register count, x0 included
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [ILEN-1:0] inst_t;
    typedef logic [ALEN-1:0] addr_t;
    typedef logic [4:0]      reg_idx_t;
    typedef logic [3:0]      trap_cause_t;

    // Major opcode, instruction bits 6:2
    typedef enum logic [4:0] {
        OP_LOAD   = 5'b00000,
        OP_OP_IMM = 5'b00100,
        OP_AUIPC  = 5'b00101,
        OP_STORE  = 5'b01000,
        OP_OP     = 5'b01100,
        OP_LUI    = 5'b01101,
        OP_BRANCH = 5'b11000,
        OP_JALR   = 5'b11001,
        OP_JAL    = 5'b11011,
        OP_SYSTEM = 5'b11100
    } opcode_t;

    // Standard mcause encoding
    localparam trap_cause_t CAUSE_ILLEGAL_INSTR = 4'd2;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
    --top-module decode_tb \
    -f decode_stage_top.f

./obj_dir/Vdecode_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
grep -q "TEST PASSED" sim.log
